/* Makefile */
TOP = tb_audio_loopback

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f audio_loopback_top.f \
		--Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* audio_loopback_top.f */
+incdir+source
source/avalon_bus_pkg.sv
source/loopback_pkg.sv
source/loopback_fsm.sv
source/bus_master_port.sv
source/sample_capture.sv
source/audio_loopback_top.sv
bench/audio_fabric_model.sv
bench/tb_audio_loopback.sv

/* bench/audio_fabric_model.sv */
`timescale 1ns/1ps

module audio_fabric_model (
	input  logic        CLOCK_50,
	input  logic        arst_n,
	input  logic [31:0] bus_addr,
	input  logic        bus_read,
	input  logic        bus_write,
	input  logic [23:0] in_list,
	input  int          n_in,
	input  logic [23:0] room_list,
	input  int          n_room,
	input  logic [31:0] sample_word,
	input  int          ack_delay,
	output logic        bus_ack,
	output logic [31:0] bus_read_data
);

	localparam logic [31:0] FIFO_ADDR  = 32'h0000_3044;
	localparam logic [31:0] RIGHT_ADDR = 32'h0000_304c;

	logic        ack_q = 1'b0;
	logic [31:0] data_q = '0;
	int          wait_cnt;
	int          in_idx;
	int          room_idx;
	logic        out_phase;

	assign bus_ack       = ack_q;
	assign bus_read_data = data_q;

	// Last entry repeats once the list runs out
	function automatic logic [7:0] list_entry(input logic [23:0] list, input int idx,
		input int len);
		int sel;
		sel = (idx < len) ? idx : len - 1;
		return list[8*sel +: 8];
	endfunction

	// Acks and read data change on the falling edge
	always @(negedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			ack_q     <= 1'b0;
			data_q    <= '0;
			wait_cnt  <= 0;
			in_idx    <= 0;
			room_idx  <= 0;
			out_phase <= 1'b0;
		end else if ((bus_read || bus_write) && !ack_q) begin
			if (wait_cnt < ack_delay) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				ack_q    <= 1'b1;
				wait_cnt <= 0;
				if (bus_read && bus_addr == FIFO_ADDR && !out_phase) begin
					data_q <= {24'h0, list_entry(in_list, in_idx, n_in)};
					in_idx <= in_idx + 1;
				end else if (bus_read && bus_addr == FIFO_ADDR) begin
					data_q   <= {list_entry(room_list, room_idx, n_room), 24'h0};
					room_idx <= room_idx + 1;
				end else if (bus_read) begin
					data_q    <= sample_word;
					out_phase <= 1'b1;
				end else if (bus_addr == RIGHT_ADDR) begin
					// Right channel write closes one loop
					in_idx    <= 0;
					room_idx  <= 0;
					out_phase <= 1'b0;
				end
			end
		end else begin
			ack_q <= 1'b0;
		end
	end

endmodule

/* bench/tb_audio_loopback.sv */
`timescale 1ns/1ps

module tb_audio_loopback;

	localparam int          NUM_ROWS        = 6;
	localparam int          MAX_DELAY       = 8;
	localparam int          WATCHDOG_CYCLES = 10 + NUM_ROWS * 8 * (MAX_DELAY + 4);
	localparam logic [7:0]  ROOM_MIN        = 8'd2;
	localparam logic [31:0] FIFO_ADDR       = 32'h0000_3044;
	localparam logic [31:0] LEFT_ADDR       = 32'h0000_3048;
	localparam logic [31:0] RIGHT_ADDR      = 32'h0000_304c;

	logic        CLOCK_50;
	logic        arst_n;
	logic        bus_ack;
	logic [31:0] bus_read_data;
	logic [31:0] bus_addr;
	logic        bus_read;
	logic        bus_write;
	logic [31:0] bus_write_data;
	logic [23:0] in_list;
	logic [23:0] room_list;
	logic [31:0] sample_word;
	int          n_in;
	int          n_room;
	int          ack_delay;

	////////////////////////////////////////////////////////////
	// Case table
	////////////////////////////////////////////////////////////

	// First list entry sits in the low byte
	string       row_name   [NUM_ROWS] = '{"ready_first", "input_empty", "room_threshold",
		"slow_ack", "room_max", "both_wait"};
	int          row_n_in   [NUM_ROWS] = '{1, 3, 1, 2, 1, 2};
	logic [23:0] row_in     [NUM_ROWS] = '{24'h000001, 24'h070000, 24'h000002, 24'h00ff00,
		24'h000080, 24'h000100};
	int          row_n_room [NUM_ROWS] = '{1, 1, 3, 2, 1, 3};
	logic [23:0] row_room   [NUM_ROWS] = '{24'h000010, 24'h000003, 24'h050102, 24'h000302,
		24'h0000ff, 24'h800000};
	logic [31:0] row_sample [NUM_ROWS] = '{32'ha5a5_1234, 32'h0bad_f00d, 32'hdead_beef,
		32'h8000_0001, 32'hffff_ffff, 32'h1357_9bdf};
	int          row_delay  [NUM_ROWS] = '{0, 2, 1, 5, 3, 4};

	// Kind 1 is a write
	int          log_kind[$];
	logic [31:0] log_addr[$];
	logic [31:0] log_data[$];
	int          exp_kind[$];
	logic [31:0] exp_addr[$];
	logic [31:0] exp_data[$];
	string       cur_name;
	int          errors;
	int          row_base;
	int          passed;
	int          failed;
	logic        prev_strobe;
	logic        prev_ack;
	logic [31:0] prev_addr;

	audio_loopback_top uut (.*);

	audio_fabric_model fabric (.*);

	always #10 CLOCK_50 = ~CLOCK_50;

	// Outputs are settled at the rising edge
	always @(posedge CLOCK_50) begin
		if (arst_n) begin
			if (bus_read && bus_write) begin
				$display("%s: read and write strobes are high together", cur_name);
				errors++;
			end
			if (prev_strobe && !prev_ack && !(bus_read || bus_write)) begin
				$display("%s: strobe dropped before its ack", cur_name);
				errors++;
			end else if (prev_strobe && !prev_ack && bus_addr != prev_addr) begin
				$display("%s: address changed while waiting for ack", cur_name);
				errors++;
			end
			if (prev_strobe && prev_ack && (bus_read || bus_write)) begin
				$display("%s: strobe still high after its ack", cur_name);
				errors++;
			end
			if ((bus_read || bus_write) && bus_ack) begin
				log_kind.push_back(bus_write ? 1 : 0);
				log_addr.push_back(bus_addr);
				log_data.push_back(bus_write ? bus_write_data : bus_read_data);
			end
		end
		prev_strobe = bus_read || bus_write;
		prev_ack    = bus_ack;
		prev_addr   = bus_addr;
	end

	task automatic expect_txn(input int kind, input logic [31:0] addr, input logic [31:0] data);
		exp_kind.push_back(kind);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic load_row(input int r);
		int extra;
		extra = 0;
		if (r % 2 == 1)
			extra = int'($urandom % 4);
		cur_name  = row_name[r];
		in_list   = row_in[r];
		n_in      = row_n_in[r];
		room_list = row_room[r];
		n_room    = row_n_room[r];
		sample_word = row_sample[r];
		ack_delay = row_delay[r] + extra;
		row_base  = errors;
		log_kind.delete();
		log_addr.delete();
		log_data.delete();
		exp_kind.delete();
		exp_addr.delete();
		exp_data.delete();
		// Status polls until the first nonzero input count
		for (int i = 0; i < row_n_in[r]; i++) begin
			expect_txn(0, FIFO_ADDR, 32'h0);
			if (row_in[r][8*i +: 8] != 8'h00)
				break;
		end
		expect_txn(0, RIGHT_ADDR, row_sample[r]);
		// Status polls until the room clears the threshold
		for (int i = 0; i < row_n_room[r]; i++) begin
			expect_txn(0, FIFO_ADDR, 32'h0);
			if (row_room[r][8*i +: 8] > ROOM_MIN)
				break;
		end
		expect_txn(1, LEFT_ADDR, row_sample[r]);
		expect_txn(1, RIGHT_ADDR, row_sample[r]);
	endtask

	task automatic check_row();
		// A loop ends with the right channel write
		while (log_kind.size() == 0 || log_kind[$] != 1 || log_addr[$] != RIGHT_ADDR)
			@(negedge CLOCK_50);
		if (log_kind.size() != exp_kind.size()) begin
			$display("Error %s: transaction count expected %0d actual %0d", cur_name,
				exp_kind.size(), log_kind.size());
			errors++;
		end
		for (int i = 0; i < exp_kind.size() && i < log_kind.size(); i++) begin
			if (log_kind[i] != exp_kind[i] || log_addr[i] != exp_addr[i]) begin
				$display("Error %s: transaction %0d expected kind %0d at %h actual kind %0d at %h",
					cur_name, i, exp_kind[i], exp_addr[i], log_kind[i], log_addr[i]);
				errors++;
			end else if (exp_kind[i] == 1 && log_data[i] != exp_data[i]) begin
				$display("Error %s: write %0d data expected %h actual %h", cur_name, i,
					exp_data[i], log_data[i]);
				errors++;
			end
		end
		if (errors == row_base) begin
			$display("Test %s passed, %0d transactions, ack delay %0d", cur_name,
				log_kind.size(), ack_delay);
			passed++;
		end else begin
			$display("Test %s failed", cur_name);
			failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reset, table loop and report
	////////////////////////////////////////////////////////////

	initial begin
		CLOCK_50 = 1'b0;
		arst_n   = 1'b0;
		errors   = 0;
		passed   = 0;
		failed   = 0;
		void'($urandom(32'h38c2));
		load_row(0);
		repeat (10) @(negedge CLOCK_50);
		if (bus_read || bus_write) begin
			$display("reset: a bus strobe is high during reset");
			errors++;
		end
		arst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (r > 0)
				load_row(r);
			check_row();
		end
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d", NUM_ROWS, passed,
			failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Whole table at the slowest ack
	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("Watchdog expired, the bus loop stopped making progress in test %s",
			cur_name);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* source/audio_config.svh */
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

////////////////////////////////////////////////////////////
// Audio core register map
////////////////////////////////////////////////////////////

`define AUDIO_BASE_ADDR    32'h0000_3040
`define AUDIO_FIFO_OFFSET  32'd4
`define AUDIO_LEFT_OFFSET  32'd8
`define AUDIO_RIGHT_OFFSET 32'd12

// Bus and FIFO count widths
`define BUS_WIDTH        32
`define FIFO_COUNT_WIDTH 8

// Output room has to exceed this before a write
`define OUT_ROOM_MIN 8'd2

`endif

/* source/audio_loopback_top.sv */
`timescale 1ns/1ps

module audio_loopback_top import avalon_bus_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      arst_n,
	input  logic      bus_ack,
	input  bus_data_t bus_read_data,
	output bus_addr_t bus_addr,
	output logic      bus_read,
	output logic      bus_write,
	output bus_data_t bus_write_data
);

	logic      start_read;
	logic      start_write;
	bus_reg_t  target;
	logic      done;
	bus_data_t read_data;
	logic      capture_status;
	logic      capture_sample;
	logic      in_ready;
	logic      out_room;
	bus_data_t sample;

	////////////////////////////////////////////////////////////
	// Sequencer, bus port and sample store
	////////////////////////////////////////////////////////////

	loopback_fsm u_fsm (
		.CLOCK_50       (CLOCK_50),
		.arst_n         (arst_n),
		.done           (done),
		.in_ready       (in_ready),
		.out_room       (out_room),
		.start_read     (start_read),
		.start_write    (start_write),
		.target         (target),
		.capture_status (capture_status),
		.capture_sample (capture_sample)
	);

	bus_master_port u_port (
		.CLOCK_50       (CLOCK_50),
		.arst_n         (arst_n),
		.start_read     (start_read),
		.start_write    (start_write),
		.target         (target),
		.write_sample   (sample),
		.bus_ack        (bus_ack),
		.bus_read_data  (bus_read_data),
		.bus_addr       (bus_addr),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_write_data (bus_write_data),
		.read_data      (read_data),
		.done           (done)
	);

	sample_capture u_capture (
		.CLOCK_50       (CLOCK_50),
		.arst_n         (arst_n),
		.capture_status (capture_status),
		.capture_sample (capture_sample),
		.read_data      (read_data),
		.in_ready       (in_ready),
		.out_room       (out_room),
		.sample         (sample)
	);

endmodule

/* source/avalon_bus_pkg.sv */
`include "audio_config.svh"

package avalon_bus_pkg;

	////////////////////////////////////////////////////////////
	// Bus words
	////////////////////////////////////////////////////////////

	// Full word address, byte addressed
	typedef logic [`BUS_WIDTH-1:0] bus_addr_t;

	// Read and write data
	typedef logic [`BUS_WIDTH-1:0] bus_data_t;

	// Register selector for one transaction
	typedef enum logic [1:0] {
		reg_fifo  = 2'd0,
		reg_left  = 2'd1,
		reg_right = 2'd2
	} bus_reg_t;

endpackage

/* source/bus_master_port.sv */
`timescale 1ns/1ps

`include "audio_config.svh"

module bus_master_port import avalon_bus_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      arst_n,
	input  logic      start_read,
	input  logic      start_write,
	input  bus_reg_t  target,
	input  bus_data_t write_sample,
	input  logic      bus_ack,
	input  bus_data_t bus_read_data,
	output bus_addr_t bus_addr,
	output logic      bus_read,
	output logic      bus_write,
	output bus_data_t bus_write_data,
	output bus_data_t read_data,
	output logic      done
);

	logic      strobe;
	bus_addr_t addr_next;

	assign strobe = bus_read || bus_write;

	// Register map lookup
	always_comb begin
		case (target)
			reg_left:  addr_next = `AUDIO_BASE_ADDR + `AUDIO_LEFT_OFFSET;
			reg_right: addr_next = `AUDIO_BASE_ADDR + `AUDIO_RIGHT_OFFSET;
			default:   addr_next = `AUDIO_BASE_ADDR + `AUDIO_FIFO_OFFSET;
		endcase
	end

	// Strobes hold until ack, then drop together with the done pulse
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			bus_read  <= 1'b0;
			bus_write <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (strobe) begin
				if (bus_ack) begin
					bus_read  <= 1'b0;
					bus_write <= 1'b0;
					done      <= 1'b1;
				end
			end else begin
				bus_read  <= start_read;
				bus_write <= start_write;
			end
		end
	end

	// Address and data only load when idle
	always_ff @(posedge CLOCK_50) begin
		if (!strobe && (start_read || start_write))
			bus_addr <= addr_next;
		if (!strobe && start_write)
			bus_write_data <= write_sample;
		if (bus_read && bus_ack)
			read_data <= bus_read_data;
	end

	a_one_strobe: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		!(bus_read && bus_write));

	a_addr_hold: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		(strobe && !bus_ack) |=> strobe && $stable(bus_addr));

endmodule

/* source/loopback_fsm.sv */
`timescale 1ns/1ps

module loopback_fsm import avalon_bus_pkg::*, loopback_pkg::*; (
	input  logic     CLOCK_50,
	input  logic     arst_n,
	input  logic     done,
	input  logic     in_ready,
	input  logic     out_room,
	output logic     start_read,
	output logic     start_write,
	output bus_reg_t target,
	output logic     capture_status,
	output logic     capture_sample
);

	loop_state_t state;
	loop_state_t state_next;
	logic        start_read_next;
	logic        start_write_next;
	bus_reg_t    target_next;
	logic        txn_open;

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	// Issue states leave once their start pulse is out
	always_comb begin
		state_next = state;
		case (state)
			poll_in:     if (start_read) state_next = wait_in;
			wait_in:     if (done) state_next = decide_in;
			decide_in:   state_next = in_ready ? read_sample : poll_in;
			read_sample: if (start_read) state_next = wait_sample;
			wait_sample: if (done) state_next = poll_out;
			poll_out:    if (start_read) state_next = wait_out;
			wait_out:    if (done) state_next = decide_out;
			decide_out:  state_next = out_room ? write_left : poll_out;
			write_left:  if (start_write) state_next = wait_left;
			wait_left:   if (done) state_next = write_right;
			write_right: if (start_write) state_next = wait_right;
			wait_right:  if (done) state_next = poll_in;
			default:     state_next = poll_in;
		endcase
	end

	// Start pulse is raised on entry to an issue state
	always_comb begin
		start_read_next  = (state_next == poll_in) || (state_next == read_sample) ||
			(state_next == poll_out);
		start_write_next = (state_next == write_left) || (state_next == write_right);
		case (state_next)
			read_sample: target_next = reg_right;
			write_left:  target_next = reg_left;
			write_right: target_next = reg_right;
			default:     target_next = reg_fifo;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= poll_in;
			start_read  <= 1'b0;
			start_write <= 1'b0;
			target      <= reg_fifo;
		end else begin
			state       <= state_next;
			start_read  <= start_read_next;
			start_write <= start_write_next;
			target      <= target_next;
		end
	end

	// Captures line up with the done pulse of the matching read
	assign capture_status = done && ((state == wait_in) || (state == wait_out));
	assign capture_sample = done && (state == wait_sample);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Open from a start pulse until the matching done
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n)
			txn_open <= 1'b0;
		else if (start_read || start_write)
			txn_open <= 1'b1;
		else if (done)
			txn_open <= 1'b0;
	end

	a_one_start: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		!(start_read && start_write));

	// Nothing new until the open transaction reports done
	a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		(start_read || start_write) |-> !txn_open);

endmodule

/* source/loopback_pkg.sv */
`include "audio_config.svh"

package loopback_pkg;

	// Word count taken from one byte of the FIFO status
	typedef logic [`FIFO_COUNT_WIDTH-1:0] fifo_count_t;

	// Loop sequence, issue states followed by their wait states
	typedef enum logic [3:0] {
		poll_in     = 4'd0,
		wait_in     = 4'd1,
		decide_in   = 4'd2,
		read_sample = 4'd3,
		wait_sample = 4'd4,
		poll_out    = 4'd5,
		wait_out    = 4'd6,
		decide_out  = 4'd7,
		write_left  = 4'd8,
		wait_left   = 4'd9,
		write_right = 4'd10,
		wait_right  = 4'd11
	} loop_state_t;

endpackage

/* source/sample_capture.sv */
`timescale 1ns/1ps

`include "audio_config.svh"

module sample_capture import avalon_bus_pkg::*, loopback_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      arst_n,
	input  logic      capture_status,
	input  logic      capture_sample,
	input  bus_data_t read_data,
	output logic      in_ready,
	output logic      out_room,
	output bus_data_t sample
);

	fifo_count_t in_count;
	fifo_count_t room_count;

	////////////////////////////////////////////////////////////
	// Status word fields
	////////////////////////////////////////////////////////////

	// Input count in the low byte, output room in the top byte
	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			in_count   <= '0;
			room_count <= '0;
		end else if (capture_status) begin
			in_count   <= read_data[`FIFO_COUNT_WIDTH-1:0];
			room_count <= read_data[`BUS_WIDTH-1 -: `FIFO_COUNT_WIDTH];
		end
	end

	// Held sample, written back to both channels
	always_ff @(posedge CLOCK_50) begin
		if (capture_sample)
			sample <= read_data;
	end

	assign in_ready = (in_count != '0);

	// Both channels share one room value
	assign out_room = (room_count > `OUT_ROOM_MIN);

	a_one_capture: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		!(capture_status && capture_sample));

	// A sample read only follows a status word with input waiting
	a_sample_needs_input: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		capture_sample |-> in_ready);

endmodule
